// ==== cpu_pkg.sv ====
/*
 * CPU core package
 * Word and index types, opcode and ALU encodings, instruction field
 * positions and the records carried between pipeline stages
 */
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;    // Data and address word
    typedef logic [4:0]      reg_idx_t; // Register index

    // --------------------
    // Encodings
    typedef enum logic [4:0] {
        OP_ALU  = 5'd0,  // R-type, ALU op in its own field
        OP_J    = 5'd1,
        OP_BNE  = 5'd2,
        OP_ADDI = 5'd5,
        OP_BLT  = 5'd6,
        OP_SW   = 5'd7,
        OP_LW   = 5'd8
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    typedef enum logic [1:0] {BYP_NONE, BYP_XM, BYP_MW} byp_sel_e;

    // --------------------
    // Instruction fields
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 27;
    localparam int RD_HI  = 26;
    localparam int RD_LO  = 22;
    localparam int RS_HI  = 21;
    localparam int RS_LO  = 17;
    localparam int RT_HI  = 16;
    localparam int RT_LO  = 12;
    localparam int SH_HI  = 11;  // Shift amount
    localparam int SH_LO  = 7;
    localparam int AOP_HI = 6;   // ALU op of R-type
    localparam int AOP_LO = 2;
    localparam int IMM_W  = 17;  // Immediate in the low bits, signed
    localparam int TGT_W  = 27;  // Jump target, unsigned

    // Port B source: rd for store and branches, rt otherwise
    function automatic reg_idx_t src_b_idx(input xlen_t instr);
        opcode_e op;
        op = opcode_e'(instr[OPC_HI:OPC_LO]);
        if (op == OP_SW || op == OP_BNE || op == OP_BLT)
            return instr[RD_HI:RD_LO];
        return instr[RT_HI:RT_LO];
    endfunction

    // --------------------
    // Pipeline records
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;    // Immediate on ALU input B
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg; // Load
        logic    is_bne;
        logic    is_blt;
        logic    is_jump;
    } ctrl_t;

    typedef struct packed {
        xlen_t pc;
        xlen_t instr;
        logic  valid;
    } fd_reg_t;

    typedef struct packed {
        xlen_t            pc;
        ctrl_t            ctrl;
        reg_idx_t         rd;
        reg_idx_t         src_a;   // Kept for the bypass compare
        reg_idx_t         src_b;
        xlen_t            a_val;
        xlen_t            b_val;
        xlen_t            imm;     // Already sign-extended
        logic [4:0]       shamt;
        logic [TGT_W-1:0] target;
        logic             valid;
    } dx_reg_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rd;
        xlen_t    result;      // ALU result or memory address
        xlen_t    store_data;
        logic     valid;
    } xm_reg_t;

    typedef struct packed {
        logic     reg_write;   // Already qualified by valid
        logic     mem_to_reg;
        reg_idx_t rd;
        xlen_t    result;
        xlen_t    load_data;
    } mw_reg_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
    } redirect_t;

    typedef struct packed {
        xlen_t addr;
        xlen_t wdata;
        logic  we;
    } dmem_req_t;

endpackage

// ==== alu.sv ====
/*
 * ALU
 * Add, sub, and, or and the two shifts, plus compare flags for branches
 */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  alu_op_e    op,
    input  xlen_t      a,
    input  xlen_t      b,
    input  logic [4:0] shamt,     // Shifts use the field, not b
    output xlen_t      result,
    output logic       not_equal,
    output logic       less_than
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = xlen_t'($signed(a) >>> shamt);
            default: result = '0;        // Unused R-type codes
        endcase
    end

    // --------------------
    // Flags
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));  // Two's complement compare

endmodule

// ==== reg_file.sv ====
/*
 * Register file
 * 32 words, two combinational reads with write-through, one write port
 */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output xlen_t    rd_data_a,
    output xlen_t    rd_data_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data
);

    xlen_t regs [32];

    // Register 0 is hardwired, a same-cycle write is seen by the read
    function automatic xlen_t read_port(input reg_idx_t idx, input xlen_t stored,
                                        input logic we, input reg_idx_t widx,
                                        input xlen_t wdata);
        if (idx == '0)
            return '0;
        if (we && widx == idx)
            return wdata;
        return stored;
    endfunction

    assign rd_data_a = read_port(rd_idx_a, regs[rd_idx_a], wr_en, wr_idx, wr_data);
    assign rd_data_b = read_port(rd_idx_b, regs[rd_idx_b], wr_en, wr_idx, wr_data);

    always_ff @(posedge clock) begin
        if (reset)
            regs <= '{default: '0};
        else if (wr_en && wr_idx != '0)
            regs[wr_idx] <= wr_data;
    end

endmodule

// ==== fetch_unit.sv ====
/*
 * Fetch stage
 * Program counter with static not-taken prediction and the fetch/decode register
 */
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
    parameter xlen_t RESET_PC = '0       // First fetch address
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      stall,             // Load-use hold
    input  redirect_t redirect,          // Taken branch or jump from execute
    output xlen_t     imem_addr,
    input  xlen_t     imem_data,
    output fd_reg_t   fd
);

    xlen_t pc;

    assign imem_addr = pc;               // Word address, read in the same cycle

    // Redirect takes priority over stall
    always_ff @(posedge clock) begin
        if (reset)
            pc <= RESET_PC;
        else if (redirect.taken)
            pc <= redirect.target;
        else if (!stall)
            pc <= pc + 32'd1;            // Predict not taken
    end

    // --------------------
    // Fetch/decode register
    always_ff @(posedge clock) begin
        if (reset) begin
            fd.valid <= 1'b0;
        end else if (redirect.taken) begin
            fd.valid <= 1'b0;            // Drop the wrong-path word
        end else if (!stall) begin
            fd.pc    <= pc;
            fd.instr <= imem_data;
            fd.valid <= 1'b1;
        end
    end

endmodule

// ==== decode_unit.sv ====
/*
 * Decode stage
 * Splits the instruction, builds the control word, reads the register file
 * and loads the decode/execute register
 */
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  fd_reg_t   fd,
    input  logic      stall,
    input  redirect_t redirect,
    input  logic      wb_en,              // Write port from writeback
    input  reg_idx_t  wb_idx,
    input  xlen_t     wb_data,
    output dx_reg_t   dx
);

    opcode_e  opcode;
    ctrl_t    ctrl;
    reg_idx_t src_a;
    reg_idx_t src_b;
    xlen_t    a_val;
    xlen_t    b_val;
    xlen_t    imm_ext;

    assign opcode  = opcode_e'(fd.instr[OPC_HI:OPC_LO]);
    assign src_a   = fd.instr[RS_HI:RS_LO];
    assign src_b   = src_b_idx(fd.instr);                 // rt, or rd for sw and branches
    assign imm_ext = {{(XLEN-IMM_W){fd.instr[IMM_W-1]}}, fd.instr[IMM_W-1:0]};

    // --------------------
    // Control generation
    always_comb begin
        ctrl = '0;                                         // Unknown opcodes become nops
        case (opcode)
            OP_ALU: begin
                ctrl.alu_op    = alu_op_e'(fd.instr[AOP_HI:AOP_LO]);
                ctrl.reg_write = 1'b1;
            end
            OP_ADDI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LW: begin
                ctrl.use_imm    = 1'b1;                    // Base plus offset
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BNE: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.is_bne = 1'b1;
            end
            OP_BLT: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.is_blt = 1'b1;
            end
            OP_J:    ctrl.is_jump = 1'b1;
            default: ;
        endcase
    end

    reg_file reg_file_inst (
        .clock     (clock),
        .reset     (reset),
        .rd_idx_a  (src_a),
        .rd_idx_b  (src_b),
        .rd_data_a (a_val),
        .rd_data_b (b_val),
        .wr_en     (wb_en),
        .wr_idx    (wb_idx),
        .wr_data   (wb_data)
    );

    // --------------------
    // Decode/execute register, bubble on stall or redirect
    always_ff @(posedge clock) begin
        if (reset) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid  <= fd.valid && !stall && !redirect.taken;
            dx.pc     <= fd.pc;
            dx.ctrl   <= ctrl;
            dx.rd     <= fd.instr[RD_HI:RD_LO];
            dx.src_a  <= src_a;
            dx.src_b  <= src_b;
            dx.a_val  <= a_val;
            dx.b_val  <= b_val;
            dx.imm    <= imm_ext;
            dx.shamt  <= fd.instr[SH_HI:SH_LO];
            dx.target <= fd.instr[TGT_W-1:0];
        end
    end

endmodule

// ==== hazard_unit.sv ====
/*
 * Hazard unit
 * Load-use stall detection and the execute-stage bypass selects
 */
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  fd_reg_t  fd,
    input  dx_reg_t  dx,
    input  xm_reg_t  xm,
    input  mw_reg_t  mw,
    output logic     stall,
    output byp_sel_e byp_a,
    output byp_sel_e byp_b
);

    opcode_e  fd_op;
    reg_idx_t fd_src_a;
    reg_idx_t fd_src_b;
    logic     uses_a;
    logic     uses_b;
    logic     load_in_ex;

    // Sources of the instruction now in decode
    assign fd_op    = opcode_e'(fd.instr[OPC_HI:OPC_LO]);
    assign fd_src_a = fd.instr[RS_HI:RS_LO];
    assign fd_src_b = src_b_idx(fd.instr);
    assign uses_a   = fd_op inside {OP_ALU, OP_ADDI, OP_LW, OP_SW, OP_BNE, OP_BLT};
    assign uses_b   = fd_op inside {OP_ALU, OP_SW, OP_BNE, OP_BLT};  // Not the imm bits

    assign load_in_ex = dx.valid && dx.ctrl.mem_to_reg && dx.rd != '0;
    assign stall = fd.valid && load_in_ex &&
                   ((uses_a && dx.rd == fd_src_a) || (uses_b && dx.rd == fd_src_b));

    // Youngest producer wins, loads in memory stage have no data yet
    function automatic byp_sel_e pick(input reg_idx_t idx, input xm_reg_t x,
                                      input mw_reg_t m);
        if (idx == '0)
            return BYP_NONE;
        if (x.valid && x.ctrl.reg_write && !x.ctrl.mem_to_reg && x.rd == idx)
            return BYP_XM;
        if (m.reg_write && m.rd == idx)
            return BYP_MW;
        return BYP_NONE;
    endfunction

    assign byp_a = pick(dx.src_a, xm, mw);
    assign byp_b = pick(dx.src_b, xm, mw);

endmodule

// ==== execute_unit.sv ====
/*
 * Execute stage
 * Operand bypass, ALU, branch and jump resolution, execute/memory register
 */
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  dx_reg_t   dx,
    input  byp_sel_e  byp_a,
    input  byp_sel_e  byp_b,
    input  xlen_t     wb_data,      // Writeback value for the MW path
    output redirect_t redirect,
    output xm_reg_t   xm
);

    xlen_t src_a;
    xlen_t src_b;
    xlen_t alu_b;
    xlen_t alu_y;
    logic  ne;
    logic  lt;
    logic  branch_taken;

    // --------------------
    // Bypass muxes
    function automatic xlen_t bypass(input byp_sel_e sel, input xlen_t reg_val,
                                     input xlen_t xm_val, input xlen_t mw_val);
        case (sel)
            BYP_XM:  return xm_val;
            BYP_MW:  return mw_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = bypass(byp_a, dx.a_val, xm.result, wb_data);
    assign src_b = bypass(byp_b, dx.b_val, xm.result, wb_data);  // Also the store data
    assign alu_b = dx.ctrl.use_imm ? dx.imm : src_b;

    alu alu_inst (
        .op        (dx.ctrl.alu_op),
        .a         (src_a),
        .b         (alu_b),
        .shamt     (dx.shamt),
        .result    (alu_y),
        .not_equal (ne),
        .less_than (lt)
    );

    // --------------------
    // Branch resolution
    // A is rs and B is rd, so rd < rs means B < A
    assign branch_taken = (dx.ctrl.is_bne && ne) || (dx.ctrl.is_blt && ne && !lt);

    assign redirect.taken  = dx.valid && (branch_taken || dx.ctrl.is_jump);
    assign redirect.target = dx.ctrl.is_jump ? xlen_t'(dx.target)
                                             : dx.pc + 32'd1 + dx.imm;

    // Execute/memory register
    always_ff @(posedge clock) begin
        if (reset) begin
            xm.valid <= 1'b0;
        end else begin
            xm.valid      <= dx.valid;
            xm.ctrl       <= dx.ctrl;
            xm.rd         <= dx.rd;
            xm.result     <= alu_y;      // Address for lw and sw
            xm.store_data <= src_b;
        end
    end

endmodule

// ==== mem_wb_unit.sv ====
/*
 * Memory and writeback stage
 * Data memory request, memory/writeback register and register write port
 */
`timescale 1ns/1ps

module mem_wb_unit import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  xm_reg_t   xm,
    output dmem_req_t dmem_req,
    input  xlen_t     dmem_rdata,   // Combinational read data
    output mw_reg_t   mw,
    output logic      wb_en,
    output reg_idx_t  wb_idx,
    output xlen_t     wb_data
);

    // Request straight from the memory-stage record
    assign dmem_req.addr  = xm.result;
    assign dmem_req.wdata = xm.store_data;
    assign dmem_req.we    = xm.valid && xm.ctrl.mem_write;

    // --------------------
    // Memory/writeback register
    always_ff @(posedge clock) begin
        if (reset) begin
            mw.reg_write <= 1'b0;
        end else begin
            mw.reg_write  <= xm.valid && xm.ctrl.reg_write;
            mw.mem_to_reg <= xm.ctrl.mem_to_reg;
            mw.rd         <= xm.rd;
            mw.result     <= xm.result;
            mw.load_data  <= dmem_rdata;
        end
    end

    assign wb_data = mw.mem_to_reg ? mw.load_data : mw.result;
    assign wb_idx  = mw.rd;
    assign wb_en   = mw.reg_write && (mw.rd != '0);  // r0 stays zero

endmodule

// ==== cpu_core.sv ====
/*
 * Pipelined CPU core
 * Five stages with full bypass and a load-use stall, memories outside
 */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic      clock,
    input  logic      reset,
    output xlen_t     imem_addr,
    input  xlen_t     imem_data,
    output dmem_req_t dmem_req,
    input  xlen_t     dmem_rdata
);

    fd_reg_t   fd;
    dx_reg_t   dx;
    xm_reg_t   xm;
    mw_reg_t   mw;
    redirect_t redirect;
    logic      stall;
    byp_sel_e  byp_a;
    byp_sel_e  byp_b;
    logic      wb_en;     // Register write port
    reg_idx_t  wb_idx;
    xlen_t     wb_data;

    // --------------------
    // Stages
    fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_inst (
        .clock(clock), .reset(reset), .stall(stall), .redirect(redirect),
        .imem_addr(imem_addr), .imem_data(imem_data), .fd(fd)
    );

    decode_unit decode_unit_inst (
        .clock(clock), .reset(reset), .fd(fd), .stall(stall), .redirect(redirect),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .dx(dx)
    );

    hazard_unit hazard_unit_inst (
        .fd(fd), .dx(dx), .xm(xm), .mw(mw),
        .stall(stall), .byp_a(byp_a), .byp_b(byp_b)
    );

    execute_unit execute_unit_inst (
        .clock(clock), .reset(reset), .dx(dx), .byp_a(byp_a), .byp_b(byp_b),
        .wb_data(wb_data), .redirect(redirect), .xm(xm)
    );

    mem_wb_unit mem_wb_unit_inst (
        .clock(clock), .reset(reset), .xm(xm), .dmem_req(dmem_req),
        .dmem_rdata(dmem_rdata), .mw(mw),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data)
    );

endmodule

// ==== cpu_core_sva.sv ====
/*
 * CPU core assertions
 * Reset, stall, redirect and data write enable properties, bound to the core
 */
`timescale 1ns/1ps

module cpu_core_sva import cpu_pkg::*; (
    input logic      clock,
    input logic      reset,
    input dmem_req_t dmem_req,
    input logic      stall,
    input redirect_t redirect
);

    // --------------------
    // Write enable held low once reset has been seen at the last edge
    assert property (@(posedge clock) $past(reset) |-> !dmem_req.we)
        else $error("data write enable high during reset");

    // Stall inserts a bubble, so never two in a row
    assert property (@(posedge clock) disable iff (reset) stall |=> !stall)
        else $error("stall high for two cycles");

    // The branch shadow is flushed, so no back-to-back redirect
    assert property (@(posedge clock) disable iff (reset) redirect.taken |=> !redirect.taken)
        else $error("redirect taken for two cycles");

    assert property (@(posedge clock) disable iff (reset) !$isunknown(dmem_req.we))
        else $error("data write enable unknown");

endmodule

bind cpu_core cpu_core_sva cpu_core_sva_inst (
    .clock    (clock),
    .reset    (reset),
    .dmem_req (dmem_req),
    .stall    (stall),
    .redirect (redirect)
);

// ==== tb_cpu_core.sv ====
/*
 * CPU core testbench
 * Builds one program from a table of rows, runs it on memory models
 * and checks every store against the expected stream
 */
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

    localparam xlen_t RESET_PC = 32'd16;          // Not zero, any word address works
    localparam xlen_t NOP      = 32'hF800_0000;   // Opcode 31 decodes as no-op
    localparam xlen_t POISON   = 32'h0000_0BAD;   // Stored only by wrong-path code
    localparam int    NUM_ROWS = 19;

    typedef enum logic [3:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_SLL, K_SRA, K_ADDI,
        K_LOADUSE, K_BNE, K_BLT, K_JUMP
    } row_kind_e;

    typedef struct packed {
        row_kind_e kind;
        logic      rnd;    // Operands from $random
        xlen_t     a;      // Goes to r1
        xlen_t     b;      // Goes to r2, shamt for shifts
        xlen_t     exp;    // Value stored to 100 + row
    } row_t;

    logic      clock;
    logic      reset;
    xlen_t     imem_addr;
    xlen_t     imem_data;
    dmem_req_t dmem_req;
    xlen_t     dmem_rdata;

    xlen_t  imem [256];
    xlen_t  dmem [256];
    xlen_t  exp_addr [$];   // Expected store stream
    xlen_t  exp_data [$];
    xlen_t  pc_build;
    xlen_t  end_pc;         // Address of the final j-to-self
    int     end_hits;
    int     cycle_count;
    int     cycle_limit;
    integer seed = 82;

    // --------------------
    // Stimulus table
    row_t rows [NUM_ROWS] = '{
        '{K_ADD,     1'b0, 32'd100,       32'hFFFF_FFF9, 32'd93},
        '{K_SUB,     1'b0, 32'd5,         32'd12,        32'hFFFF_FFF9},
        '{K_AND,     1'b0, 32'h0000_0F0F, 32'h0000_00FF, 32'h0000_000F},
        '{K_OR,      1'b0, 32'h0000_1200, 32'h0000_0034, 32'h0000_1234},
        '{K_SLL,     1'b0, 32'd3,         32'd4,         32'd48},
        '{K_SRA,     1'b0, 32'hFFFF_FF00, 32'd4,         32'hFFFF_FFF0},
        '{K_ADDI,    1'b0, 32'd1000,      32'hFFFF_FFFF, 32'd999},
        '{K_LOADUSE, 1'b0, 32'd41,        32'd0,         32'd42},
        '{K_BNE,     1'b0, 32'd3,         32'd4,         32'd3},           // Taken
        '{K_BLT,     1'b0, 32'd5,         32'hFFFF_FFFE, 32'd5},           // -2 < 5, taken
        '{K_BLT,     1'b0, 32'hFFFF_FFFE, 32'd5,         32'hFFFF_FFFE},   // Not taken
        '{K_BNE,     1'b0, 32'd9,         32'd9,         32'd9},           // Equal, falls through
        '{K_JUMP,    1'b0, 32'd77,        32'd0,         32'd77},
        '{K_ADD,     1'b1, 32'd0,         32'd0,         32'd0},
        '{K_SUB,     1'b1, 32'd0,         32'd0,         32'd0},
        '{K_SRA,     1'b1, 32'd0,         32'd0,         32'd0},
        '{K_BLT,     1'b1, 32'd0,         32'd0,         32'd0},
        '{K_LOADUSE, 1'b1, 32'd0,         32'd0,         32'd0},
        '{K_OR,      1'b1, 32'd0,         32'd0,         32'd0}
    };

    cpu_core #(.RESET_PC(RESET_PC)) cpu_core_inst (
        .clock(clock), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata)
    );

    // Memory models, both read in the same cycle
    assign imem_data  = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_req.addr[7:0]];

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // --------------------
    // Helpers
    task automatic check_value(input string what, input xlen_t got, input xlen_t expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic xlen_t sext17(input xlen_t v);
        return {{15{v[16]}}, v[16:0]};   // Immediate range
    endfunction

    // Stored value from the ISA rules
    function automatic xlen_t isa_result(input row_kind_e k, input xlen_t a, input xlen_t b);
        case (k)
            K_ADD, K_ADDI: return a + b;
            K_SUB:         return a - b;
            K_AND:         return a & b;
            K_OR:          return a | b;
            K_SLL:         return a << b[4:0];
            K_SRA:         return xlen_t'($signed(a) >>> b[4:0]);
            K_LOADUSE:     return a + 32'd1;
            default:       return a;       // Flow rows store r1
        endcase
    endfunction

    // Branch compares rd (r2) with rs (r1)
    function automatic bit is_taken(input row_kind_e k, input xlen_t a, input xlen_t b);
        case (k)
            K_BNE:   return b != a;
            K_BLT:   return $signed(b) < $signed(a);
            K_JUMP:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic xlen_t enc_itype(input opcode_e op, input reg_idx_t rd,
                                        input reg_idx_t rs, input xlen_t imm);
        return {op, rd, rs, imm[16:0]};
    endfunction

    // r3 = r1 op r2
    function automatic xlen_t enc_rtype(input alu_op_e op, input logic [4:0] shamt);
        return {OP_ALU, 5'd3, 5'd1, 5'd2, shamt, op, 2'b00};
    endfunction

    function automatic xlen_t enc_jump(input xlen_t target);
        return {OP_J, target[26:0]};
    endfunction

    task automatic emit(input xlen_t word);
        imem[pc_build[7:0]] = word;
        pc_build = pc_build + 32'd1;
    endtask

    // --------------------
    // Program builder, one block of code per row
    task automatic build_program();
        row_t  row;
        xlen_t slot;
        bit    taken;
        for (int n = 0; n < 256; n++)
            imem[n] = NOP;
        pc_build = RESET_PC;
        emit(enc_itype(OP_ADDI, 5'd6, 5'd0, POISON));      // r6 = poison
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = rows[i];
            if (row.rnd) begin
                row.a   = sext17($random(seed));
                row.b   = sext17($random(seed));
                row.exp = isa_result(row.kind, row.a, row.b);
            end
            slot  = xlen_t'(100 + i);
            taken = is_taken(row.kind, row.a, row.b);
            emit(enc_itype(OP_ADDI, 5'd1, 5'd0, row.a));    // Back to back, both bypass paths
            emit(enc_itype(OP_ADDI, 5'd2, 5'd0, row.b));
            case (row.kind)
                K_ADD:  emit(enc_rtype(ALU_ADD, 5'd0));
                K_SUB:  emit(enc_rtype(ALU_SUB, 5'd0));
                K_AND:  emit(enc_rtype(ALU_AND, 5'd0));
                K_OR:   emit(enc_rtype(ALU_OR, 5'd0));
                K_SLL:  emit(enc_rtype(ALU_SLL, row.b[4:0]));
                K_SRA:  emit(enc_rtype(ALU_SRA, row.b[4:0]));
                K_ADDI: emit(enc_itype(OP_ADDI, 5'd3, 5'd1, row.b));
                K_LOADUSE: begin
                    exp_addr.push_back(slot + 32'd100);        // Scratch store comes first
                    exp_data.push_back(row.a);
                    emit(enc_itype(OP_SW, 5'd1, 5'd0, slot + 32'd100));
                    emit(enc_itype(OP_LW, 5'd4, 5'd0, slot + 32'd100));
                    emit(enc_itype(OP_ADDI, 5'd3, 5'd4, 32'd1));  // Needs the load at once
                end
                default: begin
                    if (row.kind == K_JUMP)
                        emit(enc_jump(pc_build + 32'd3));
                    else if (row.kind == K_BNE)
                        emit(enc_itype(OP_BNE, 5'd2, 5'd1, 32'd2));  // Target is pc + 3
                    else
                        emit(enc_itype(OP_BLT, 5'd2, 5'd1, 32'd2));
                    if (taken) begin
                        emit(enc_itype(OP_SW, 5'd6, 5'd0, slot));   // Shadow, must vanish
                        emit(enc_itype(OP_SW, 5'd6, 5'd0, slot));
                        emit(enc_itype(OP_SW, 5'd1, 5'd0, slot));   // Target
                    end else begin
                        emit(enc_itype(OP_SW, 5'd1, 5'd0, slot));   // Fall through
                        emit(NOP);
                        emit(NOP);
                    end
                end
            endcase
            if (!(row.kind inside {K_BNE, K_BLT, K_JUMP}))
                emit(enc_itype(OP_SW, 5'd3, 5'd0, slot));
            exp_addr.push_back(slot);
            exp_data.push_back(row.exp);
        end
        end_pc = pc_build;
        emit(enc_jump(pc_build));                            // j-to-self
        cycle_limit = 4 * int'(pc_build - RESET_PC) + 50;
    endtask

    // --------------------
    // Store monitor and data memory write
    always @(posedge clock) begin
        if (dmem_req.we === 1'b1) begin
            dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
            if (exp_addr.size() == 0) begin
                $display("store to address %0d with no expected store left", dmem_req.addr);
                $display("STATUS: FAIL");
                $fatal(1, "unexpected store");
            end else begin
                check_value("store address", dmem_req.addr, exp_addr.pop_front());
                check_value("store data", dmem_req.wdata, exp_data.pop_front());
            end
        end
    end

    // Fetches of the final jump and the cycle limit
    always @(posedge clock) begin
        if (reset) begin
            end_hits    <= 0;
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (imem_addr == end_pc)
                end_hits <= end_hits + 1;
            if (cycle_count >= cycle_limit) begin
                $display("timeout, program did not finish within %0d cycles", cycle_limit);
                $display("STATUS: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    // --------------------
    // Main sequence
    initial begin
        reset = 1'b1;
        build_program();
        repeat (10) begin
            @(posedge clock);
            #1;
            check_value("write enable in reset", {31'd0, dmem_req.we}, 32'd0);
        end
        check_value("first fetch address", imem_addr, RESET_PC);
        reset = 1'b0;
        wait (end_hits >= 2);                                // Jump has looped back once
        repeat (8) @(posedge clock);                         // No late stores
        if (exp_addr.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("%0d expected stores never arrived", exp_addr.size());
            $display("STATUS: FAIL");
            $fatal(1, "missing stores");
        end
    end

endmodule

// ==== all.f ====
cpu_pkg.sv
alu.sv
reg_file.sv
fetch_unit.sv
decode_unit.sv
hazard_unit.sv
execute_unit.sv
mem_wb_unit.sv
cpu_core.sv
cpu_core_sva.sv
tb_cpu_core.sv

// ==== Makefile ====
# Verilator build and run for the CPU core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_cpu_core
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := STATUS: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
